// File: src.f
hw/ctr_pkg.sv
hw/ctr_incr_fsm.sv
hw/ctr_slice_cnt.sv
hw/ctr_slice_add.sv
hw/ctr_state_reg.sv
hw/ctr_top.sv
sim/ctr_tb.sv

// File: sim/ctr_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ctr_tb;

  localparam int WAIT_LIMIT = 40; // Cycles per wait before giving up
  localparam int ACK_LAT    = 9;  // Edges from req sample to ack rise
  localparam int NUM_RAND   = 20;

  logic               clk;
  logic               arst_n_i;
  logic               load_i;
  ctr_pkg::ctr_word_u ctr_load_i;
  logic               incr_req_i;
  logic               incr_ack_o;
  logic               busy_o;
  ctr_pkg::ctr_word_u ctr_o;

  int          n_checks;
  int          n_errors;
  int          n_timeouts;
  logic [15:0] lfsr_q; // Random source state

  ctr_top dut_i (
    .clk_i      (clk),
    .arst_n_i   (arst_n_i),
    .load_i     (load_i),
    .ctr_load_i (ctr_load_i),
    .incr_req_i (incr_req_i),
    .incr_ack_o (incr_ack_o),
    .busy_o     (busy_o),
    .ctr_o      (ctr_o)
  );

  always #5 clk = ~clk; // 10 ns period

  //////////////////////////////
  // Helpers
  //////////////////////////////

  // x^16 + x^14 + x^13 + x^11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  // One LFSR step per bit taken
  task automatic rand_value(output logic [127:0] v);
    v = '0;
    for (int i = 0; i < 128; i++) begin
      v      = {v[126:0], lfsr_q[15]};
      lfsr_q = lfsr_next(lfsr_q);
    end
  endtask

  // Integer to big-endian word, byte 0 most significant
  function automatic ctr_pkg::ctr_word_u to_word(input logic [127:0] v);
    ctr_pkg::ctr_word_u w;
    for (int i = 15; i >= 0; i--) begin
      w.bytes[i] = v[7:0]; // Lowest byte lands at the end
      v          = v >> 8;
    end
    return w;
  endfunction

  task automatic check_word(input string name, input ctr_pkg::ctr_word_u expected,
                            input ctr_pkg::ctr_word_u actual);
    n_checks++;
    if (actual !== expected) begin
      n_errors++;
      $display("error at %0t: %s expected %h got %h", $time, name,
               expected.slices, actual.slices);
    end
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    n_checks++;
    if (actual !== expected) begin
      n_errors++;
      $display("error at %0t: %s expected %b got %b", $time, name, expected, actual);
    end
  endtask

  task automatic check_count(input string name, input int expected, input int actual);
    n_checks++;
    if (actual != expected) begin
      n_errors++;
      $display("error at %0t: %s expected %0d got %0d", $time, name, expected, actual);
    end
  endtask

  //////////////////////////////
  // Bus actions
  //////////////////////////////

  // Value shows on ctr_o at the negedge this returns on
  task automatic load_value(input logic [127:0] v);
    @(negedge clk);
    load_i     = 1'b1;
    ctr_load_i = to_word(v);
    @(negedge clk);
    load_i     = 1'b0;
  endtask

  // Counts cycles until ack reaches level while busy holds
  task automatic wait_ack(input logic level, output int cycles);
    bit seen;
    seen   = 1'b0;
    cycles = 0;
    for (int t = 0; t < WAIT_LIMIT; t++) begin
      @(negedge clk);
      if (incr_ack_o === level) begin
        seen = 1'b1;
        break;
      end
      check_bit("busy_o", 1'b1, busy_o); // Still mid-operation
      cycles++;
    end
    if (!seen) begin
      n_timeouts++;
      $display("timeout at %0t: incr_ack_o did not go %s within %0d cycles",
               $time, level ? "high" : "low", WAIT_LIMIT);
    end
  endtask

  // Full four-phase cycle
  task automatic handshake(output int cycles);
    int dummy;
    @(negedge clk);
    incr_req_i = 1'b1;
    wait_ack(1'b1, cycles);
    incr_req_i = 1'b0; // Drop on the negedge ack was seen
    wait_ack(1'b0, dummy);
    check_bit("busy_o", 1'b0, busy_o); // Back in idle
  endtask

  //////////////////////////////
  // Tests
  //////////////////////////////

  task automatic reset_and_load();
    logic [127:0] v;
    check_word("ctr_o", to_word('0), ctr_o);
    check_bit("incr_ack_o", 1'b0, incr_ack_o);
    check_bit("busy_o", 1'b0, busy_o);
    v = 128'h0123_4567_89ab_cdef_fedc_ba98_7654_3210;
    load_value(v);
    check_word("ctr_o", to_word(v), ctr_o);
  endtask

  task automatic single_increment();
    logic [127:0] v;
    int           cycles;
    v = 128'h0011_2233_4455_6677_8899_aabb_ccdd_eeff;
    load_value(v);
    handshake(cycles);
    check_count("ack latency", ACK_LAT, cycles);
    check_word("ctr_o", to_word(v + 128'd1), ctr_o);
    check_bit("incr_ack_o", 1'b0, incr_ack_o);
  endtask

  task automatic carry_and_wrap();
    logic [127:0] vals [4];
    int           cycles;
    vals[0] = 128'h0000_0000_0000_0000_0000_0000_0000_ffff; // One slice
    vals[1] = 128'h0000_0000_0000_0007_ffff_ffff_ffff_ffff; // Four slices
    vals[2] = 128'h1234_ffff_ffff_ffff_ffff_ffff_ffff_ffff; // Into the top slice
    vals[3] = '1;                                           // Full wrap
    foreach (vals[i]) begin
      load_value(vals[i]);
      handshake(cycles);
      check_word("ctr_o", to_word(vals[i] + 128'd1), ctr_o);
    end
    check_word("ctr_o", to_word('0), ctr_o); // Wrap lands on zero
  endtask

  task automatic held_request();
    logic [127:0] v;
    int           cycles;
    v = 128'h00aa_0000_0000_0000_0000_0000_0000_fffe;
    load_value(v);
    @(negedge clk);
    incr_req_i = 1'b1;
    wait_ack(1'b1, cycles);
    repeat (12) begin // Req stays high past ack
      @(negedge clk);
      check_bit("incr_ack_o", 1'b1, incr_ack_o);
      check_bit("busy_o", 1'b1, busy_o);
      check_word("ctr_o", to_word(v + 128'd1), ctr_o); // No second increment
    end
    incr_req_i = 1'b0;
    wait_ack(1'b0, cycles);
    check_count("ack release", 0, cycles); // Falls at the first edge after req drops
    check_word("ctr_o", to_word(v + 128'd1), ctr_o);
    handshake(cycles);
    check_word("ctr_o", to_word(v + 128'd2), ctr_o); // Exactly one more
  endtask

  task automatic load_while_busy();
    logic [127:0] v;
    logic [127:0] w;
    int           cycles;
    v = 128'h5555_0000_1111_2222_3333_4444_5555_ffff;
    w = 128'hdead_beef_0000_0000_0000_0000_cafe_f00d;
    load_value(v);
    @(negedge clk);
    incr_req_i = 1'b1;
    repeat (3) @(negedge clk);
    load_i     = 1'b1; // Pulse mid-increment
    ctr_load_i = to_word(w);
    @(negedge clk);
    load_i     = 1'b0;
    wait_ack(1'b1, cycles);
    load_i     = 1'b1; // Pulse while ack is high
    @(negedge clk);
    load_i     = 1'b0;
    incr_req_i = 1'b0;
    wait_ack(1'b0, cycles);
    check_word("ctr_o", to_word(v + 128'd1), ctr_o);
  endtask

  task automatic random_values();
    logic [127:0] v;
    int           cycles;
    for (int n = 0; n < NUM_RAND; n++) begin
      rand_value(v);
      load_value(v);
      check_word("ctr_o", to_word(v), ctr_o);
      handshake(cycles);
      check_word("ctr_o", to_word(v + 128'd1), ctr_o); // Mod 2^128 by width
    end
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    clk        = 1'b0;
    arst_n_i   = 1'b0;
    load_i     = 1'b0;
    ctr_load_i = '0;
    incr_req_i = 1'b0;
    n_checks   = 0;
    n_errors   = 0;
    n_timeouts = 0;
    lfsr_q     = 16'd85; // Seed

    repeat (4) @(posedge clk);
    @(negedge clk);
    arst_n_i = 1'b1;

    reset_and_load();
    single_increment();
    carry_and_wrap();
    held_request();
    load_while_busy();
    random_values();

    repeat (2) @(negedge clk);
    $display("checks %0d, value errors %0d, timeouts %0d", n_checks, n_errors, n_timeouts);
    if (n_errors == 0 && n_timeouts == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: hw/ctr_top.sv
`timescale 1ns/1ps
`default_nettype none

// CTR-mode counter engine
// Increment walks all eight slices, so every increment takes the same time
module ctr_top (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  logic               load_i,     // Load strobe
  input  ctr_pkg::ctr_word_u ctr_load_i, // Big-endian initial value
  input  logic               incr_req_i, // Four-phase request
  output logic               incr_ack_o, // Four-phase acknowledge
  output logic               busy_o,
  output ctr_pkg::ctr_word_u ctr_o       // Big-endian counter
);

  logic                            step;       // FSM to counter and adder
  logic                            first;      // FSM to adder
  logic                            load_en;    // FSM to storage
  logic                            last_slice; // Counter to FSM
  logic [ctr_pkg::CTR_IDX_W-1:0]   idx;        // Counter to adder and storage
  logic [ctr_pkg::CTR_SLICE_W-1:0] slice;      // Storage to adder
  ctr_pkg::ctr_slice_wr_t          wr;         // Adder to storage

  //////////////////////////////
  // Control
  //////////////////////////////

  ctr_incr_fsm u_fsm (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .incr_req_i   (incr_req_i),
    .load_i       (load_i),
    .last_slice_i (last_slice),
    .step_o       (step),
    .first_o      (first),
    .load_en_o    (load_en),
    .incr_ack_o   (incr_ack_o),
    .busy_o       (busy_o)
  );

  ctr_slice_cnt u_cnt (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .step_i   (step),
    .idx_o    (idx),
    .last_o   (last_slice)
  );

  //////////////////////////////
  // Datapath
  //////////////////////////////

  ctr_slice_add u_add (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .step_i   (step),
    .first_i  (first),
    .idx_i    (idx),
    .slice_i  (slice),
    .wr_o     (wr)
  );

  ctr_state_reg u_reg (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .load_en_i  (load_en),
    .ctr_load_i (ctr_load_i),
    .idx_i      (idx),
    .wr_i       (wr),
    .slice_o    (slice),
    .ctr_o      (ctr_o)
  );

endmodule

`default_nettype wire

// File: hw/ctr_state_reg.sv
`timescale 1ns/1ps
`default_nettype none

// Counter storage, held as a plain little-endian integer
module ctr_state_reg (
  input  logic                            clk_i,
  input  logic                            arst_n_i,
  input  logic                            load_en_i,  // Accepted load
  input  ctr_pkg::ctr_word_u              ctr_load_i, // Big-endian initial value
  input  logic [ctr_pkg::CTR_IDX_W-1:0]   idx_i,      // Slice to read
  input  ctr_pkg::ctr_slice_wr_t          wr_i,       // Slice to write back
  output logic [ctr_pkg::CTR_SLICE_W-1:0] slice_o,
  output ctr_pkg::ctr_word_u              ctr_o       // Big-endian counter
);

  localparam int unsigned NUM_BYTES = ctr_pkg::CTR_W / 8;

  ctr_pkg::ctr_word_u ctr_q; // Internal order, bytes[0] least significant

  // Swap between big-endian outside and little-endian inside
  // Same mapping both ways
  function automatic ctr_pkg::ctr_word_u rev_bytes(ctr_pkg::ctr_word_u in);
    ctr_pkg::ctr_word_u out;
    for (int i = 0; i < NUM_BYTES; i++) begin
      out.bytes[i] = in.bytes[NUM_BYTES-1-i];
    end
    return out;
  endfunction

  //////////////////////////////
  // Storage
  //////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ctr_q <= '0;
    end else if (load_en_i) begin
      ctr_q <= rev_bytes(ctr_load_i); // Whole word
    end else if (wr_i.we) begin
      ctr_q.slices[wr_i.idx] <= wr_i.data; // One slice per step
    end
  end

  //////////////////////////////
  // Read-out
  //////////////////////////////

  assign slice_o = ctr_q.slices[idx_i]; // Feeds the adder
  assign ctr_o   = rev_bytes(ctr_q);

  // Loads are held off while slices are written
  a_no_load_during_write : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(load_en_i && wr_i.we))
    else $error("load and slice write in the same cycle, slice %0d", wr_i.idx);

endmodule

`default_nettype wire

// File: hw/ctr_slice_add.sv
`timescale 1ns/1ps
`default_nettype none

// One 16-bit adder, reused for every slice
module ctr_slice_add (
  input  logic                            clk_i,
  input  logic                            arst_n_i,
  input  logic                            step_i,  // Slice valid this cycle
  input  logic                            first_i, // Inject the +1
  input  logic [ctr_pkg::CTR_IDX_W-1:0]   idx_i,
  input  logic [ctr_pkg::CTR_SLICE_W-1:0] slice_i,
  output ctr_pkg::ctr_slice_wr_t          wr_o
);

  logic                          carry_q; // Carry into the next slice
  logic                          carry_in;
  logic [ctr_pkg::CTR_SLICE_W:0] sum;     // Extra bit is carry out

  assign carry_in = first_i ? 1'b1 : carry_q;
  assign sum      = {1'b0, slice_i} + {{ctr_pkg::CTR_SLICE_W{1'b0}}, carry_in};

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      carry_q <= 1'b0;
    end else if (step_i) begin
      carry_q <= sum[ctr_pkg::CTR_SLICE_W]; // Ripple to next slice
    end
  end

  // Write-back straight from the adder
  always_comb begin
    wr_o.we   = step_i;
    wr_o.idx  = idx_i;
    wr_o.data = sum[ctr_pkg::CTR_SLICE_W-1:0];
  end

endmodule

`default_nettype wire

// File: hw/ctr_slice_cnt.sv
`timescale 1ns/1ps
`default_nettype none

// Slice index for the iterative increment
module ctr_slice_cnt (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  input  logic                          step_i, // Advance one slice
  output logic [ctr_pkg::CTR_IDX_W-1:0] idx_o,  // Current slice, LSB slice first
  output logic                          last_o  // Top slice reached
);

  logic [ctr_pkg::CTR_IDX_W-1:0] idx_q;

  // Natural wrap from top back to zero
  // leaves the index cleared for the next increment
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      idx_q <= '0;
    end else if (step_i) begin
      idx_q <= idx_q + 1'b1;
    end
  end

  assign idx_o  = idx_q;
  assign last_o = (idx_q == ctr_pkg::CTR_IDX_W'(ctr_pkg::CTR_NUM_SLICES - 1));

  // Every increment starts from slice 0
  a_idx_zero_at_start : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $rose(step_i) |-> (idx_q == '0))
    else $error("slice index %0d at start of increment", idx_q);

endmodule

`default_nettype wire

// File: hw/ctr_incr_fsm.sv
`timescale 1ns/1ps
`default_nettype none

// Sequences one increment over all slices and runs the req/ack handshake
module ctr_incr_fsm (
  input  logic clk_i,
  input  logic arst_n_i,
  input  logic incr_req_i,   // Four-phase request
  input  logic load_i,       // Raw load strobe
  input  logic last_slice_i, // Slice counter at top index
  output logic step_o,       // Process one slice
  output logic first_o,      // First slice of an increment
  output logic load_en_o,    // Qualified load
  output logic incr_ack_o,   // Four-phase acknowledge
  output logic busy_o
);

  ctr_pkg::ctr_fsm_e state_q, state_d;
  logic              first_q;
  logic              ack_q, ack_d;

  //////////////////////////////
  // Next state
  //////////////////////////////

  always_comb begin
    state_d = state_q;
    ack_d   = 1'b0;
    case (state_q)
      ctr_pkg::CTR_IDLE: begin
        if (incr_req_i) begin
          state_d = ctr_pkg::CTR_INCR;
        end
      end
      ctr_pkg::CTR_INCR: begin
        if (last_slice_i) begin // Eighth step done
          state_d = ctr_pkg::CTR_ACK;
        end
      end
      ctr_pkg::CTR_ACK: begin
        ack_d = 1'b1; // Raise one cycle after the last write
        if (ack_q && !incr_req_i) begin
          state_d = ctr_pkg::CTR_IDLE;
          ack_d   = 1'b0;
        end
      end
      default: begin
        state_d = ctr_pkg::CTR_IDLE; // Unused encoding
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= ctr_pkg::CTR_IDLE;
      ack_q   <= 1'b0;
      first_q <= 1'b0;
    end else begin
      state_q <= state_d;
      ack_q   <= ack_d;
      first_q <= (state_q == ctr_pkg::CTR_IDLE) && incr_req_i; // Marks the first step
    end
  end

  //////////////////////////////
  // Outputs
  //////////////////////////////

  assign step_o     = (state_q == ctr_pkg::CTR_INCR);
  assign first_o    = first_q;
  assign incr_ack_o = ack_q;
  assign busy_o     = (state_q != ctr_pkg::CTR_IDLE);
  assign load_en_o  = load_i && (state_q == ctr_pkg::CTR_IDLE) && !ack_q; // No load mid-op

  // Ack only while parked in the ack state
  a_ack_in_ack : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    ack_q |-> (state_q == ctr_pkg::CTR_ACK))
    else $error("incr_ack_o high in state %s", state_q.name());

  // Idle never steps, and never carries a stale first flag
  a_no_step_idle : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (state_q == ctr_pkg::CTR_IDLE) |-> !step_o && !first_o)
    else $error("step_o or first_o high in state %s", state_q.name());

endmodule

`default_nettype wire

// File: hw/ctr_pkg.sv
`default_nettype none

// Shared types and sizes for the CTR-mode counter engine
package ctr_pkg;

  //////////////////////////////
  // Sizes
  //////////////////////////////

  localparam int unsigned CTR_W          = 128;                        // Full counter
  localparam int unsigned CTR_SLICE_W    = 16;                         // One adder pass
  localparam int unsigned CTR_NUM_SLICES = CTR_W / CTR_SLICE_W;        // 8 passes
  localparam int unsigned CTR_IDX_W      = $clog2(CTR_NUM_SLICES);     // 3 bits

  //////////////////////////////
  // Counter word
  //////////////////////////////

  // One 128-bit word seen two ways
  // Outside view is big-endian: bytes[0] (bits 7:0) is the most significant counter byte
  // Inside storage the bytes are reversed so the word is a plain integer
  typedef union packed {
    logic [CTR_W/8-1:0][7:0]                   bytes;  // Byte view for order reversal
    logic [CTR_NUM_SLICES-1:0][CTR_SLICE_W-1:0] slices; // Slice view for read/write
  } ctr_word_u;

  // Slice write-back from adder to storage
  typedef struct packed {
    logic                   we;   // Write strobe
    logic [CTR_IDX_W-1:0]   idx;  // Target slice
    logic [CTR_SLICE_W-1:0] data; // New slice value
  } ctr_slice_wr_t;

  //////////////////////////////
  // FSM
  //////////////////////////////

  typedef enum logic [1:0] {
    CTR_IDLE = 2'b00, // Waiting for req, loads allowed
    CTR_INCR = 2'b01, // Stepping through the slices
    CTR_ACK  = 2'b10  // Holding ack until req drops
  } ctr_fsm_e;

endpackage

`default_nettype wire
